// File: Makefile
TOP = pcpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

// File: source/cpuPkg.sv
package cpuPkg;

	//////////////////////////////
	// Major opcodes
	//////////////////////////////
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	// Function field of SPECIAL
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	//////////////////////////////
	// Control encodings
	//////////////////////////////
	typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT, LUI} aluOp_t;

	// Where the written-back value comes from
	typedef enum logic {ALU, MEM} wbSrc_t;

	//////////////////////////////
	// Instruction word
	//////////////////////////////
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rType_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iType_t;

	typedef union packed {
		rType_t rType;
		iType_t iType;
	} instWord_t;

endpackage

// File: source/gprFwdUnit.sv
module gprFwdUnit (
	input logic [31:0] regFileVal,
	input logic [4:0] regRequest,
	input logic regUse,
	input logic [4:0] exWbReg,
	input logic exValid,
	input logic exIsLoad,
	input logic [31:0] exResult,
	input logic [4:0] memWbReg,
	input logic memValid,
	input logic [31:0] memResult,
	output logic [31:0] dataOut,
	output logic stall
);

	logic exHit;
	logic memHit;

	// Producers match by register number, r0 never forwards
	assign exHit = regUse && exValid && exWbReg == regRequest && regRequest != 5'd0;
	assign memHit = regUse && memValid && memWbReg == regRequest && regRequest != 5'd0;

	// Youngest producer wins
	always_comb
	begin
		if (exHit)
			dataOut = exResult;
		else if (memHit)
			dataOut = memResult;
		else
			dataOut = regFileVal;
	end

	// Load data is not ready until MEM
	assign stall = exHit && exIsLoad;

endmodule

// File: source/pcpu.sv
module pcpu #(
	parameter logic [31:0] RESET_PC = 32'hbfc0_0000
)(
	input logic clk,
	input logic rst,
	input logic iStall,
	input logic dStall,
	// Instruction data returns before the next edge
	output logic [31:0] addrIBus,
	output logic stbIBus,
	input logic [31:0] instIn,
	output logic [31:0] addrDBus,
	output logic [31:0] dataOut,
	output logic [3:0] dataMask,
	output logic memWE,
	output logic stbDBus,
	input logic [31:0] dataIn,
	output logic [31:0] dbgIdPC,
	output logic [31:0] dbgExPC,
	output logic [31:0] dbgMemPC
);

	logic masterStall, hazard, ifStall, idFlush;
	logic rsHazard, rtHazard;
	logic [31:0] ifPc, idPcTrace;
	logic [4:0] rsAddr, rtAddr;
	logic rsUse, rtUse;
	logic [31:0] rsReg, rtReg, rsFwd, rtFwd;
	logic [31:0] nextPC;
	logic branchTaken;
	logic [31:0] exResult;
	logic exIsLoad;
	logic [4:0] wbReg;
	logic [31:0] wbData;
	logic wbEn;

	idExIf idEx();
	exMemIf exMem();

	//////////////////////////////
	// Stall and flush network
	//////////////////////////////
	// Bus stalls freeze everything, a load-use hazard bubbles EX
	assign masterStall = iStall | dStall;
	assign hazard = rsHazard | rtHazard;
	assign ifStall = masterStall | hazard;
	assign idFlush = hazard & ~masterStall;

	//////////////////////////////
	// Fetch
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
			ifPc <= RESET_PC;
		else if (!ifStall)
			ifPc <= branchTaken ? nextPC : ifPc + 32'd4;
	end

	// Tracks the PC that entered decode
	always_ff @(posedge clk)
	begin
		if (!ifStall)
			idPcTrace <= ifPc;
	end

	assign addrIBus = ifPc;
	assign stbIBus = ~rst;

	regFile gpr (.clk(clk), .rst(rst), .stall(masterStall),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .rdAddr(wbReg), .rdData(wbData),
		.rdEn(wbEn), .rs(rsReg), .rt(rtReg));

	gprFwdUnit fwdRs (.regFileVal(rsReg), .regRequest(rsAddr), .regUse(rsUse),
		.exWbReg(idEx.wbReg), .exValid(idEx.valid), .exIsLoad(exIsLoad),
		.exResult(exResult), .memWbReg(exMem.wbReg), .memValid(exMem.valid),
		.memResult(wbData), .dataOut(rsFwd), .stall(rsHazard));

	gprFwdUnit fwdRt (.regFileVal(rtReg), .regRequest(rtAddr), .regUse(rtUse),
		.exWbReg(idEx.wbReg), .exValid(idEx.valid), .exIsLoad(exIsLoad),
		.exResult(exResult), .memWbReg(exMem.wbReg), .memValid(exMem.valid),
		.memResult(wbData), .dataOut(rtFwd), .stall(rtHazard));

	stageId idStage (.clk(clk), .rst(rst), .stall(ifStall), .flush(idFlush),
		.instIn(instIn), .pc(ifPc), .rsFwd(rsFwd), .rtFwd(rtFwd),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .rsUse(rsUse), .rtUse(rtUse),
		.nextPC(nextPC), .branchTaken(branchTaken), .ex(idEx.idSide));

	stageEx exStage (.clk(clk), .rst(rst), .stall(masterStall),
		.id(idEx.exSide), .mem(exMem.exSide2), .exResult(exResult),
		.exIsLoad(exIsLoad), .addrDBus(addrDBus), .dataOut(dataOut),
		.stbDBus(stbDBus), .memWE(memWE), .dataMask(dataMask));

	stageMem memStage (.clk(clk), .rst(rst), .stall(masterStall),
		.ex(exMem.memSide), .dataIn(dataIn), .wbReg(wbReg),
		.wbData(wbData), .wbEn(wbEn));

	assign dbgIdPC = idPcTrace;
	assign dbgExPC = idEx.pc;
	assign dbgMemPC = exMem.pc;

	// A frozen empty EX slot must not start a bus cycle
	noStrobeWhileFrozen: assert property (
		@(posedge clk) disable iff (rst)
		(masterStall && !idEx.valid) |=> !stbDBus
	);

endmodule

// File: source/pipeIf.sv
// ID to EX pipeline register contents
interface idExIf;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] storeData;
	cpuPkg::aluOp_t aluOp;
	logic memRead;
	logic memWrite;
	cpuPkg::wbSrc_t wbSrc;
	logic [4:0] wbReg;
	logic valid;
	logic [31:0] pc;

	modport idSide (output opA, opB, storeData, aluOp, memRead, memWrite,
		wbSrc, wbReg, valid, pc);
	modport exSide (input opA, opB, storeData, aluOp, memRead, memWrite,
		wbSrc, wbReg, valid, pc);
endinterface

// EX to MEM pipeline register contents
interface exMemIf;
	logic [31:0] aluOut;
	cpuPkg::wbSrc_t wbSrc;
	logic [4:0] wbReg;
	logic valid;
	logic [31:0] pc;

	modport exSide2 (output aluOut, wbSrc, wbReg, valid, pc);
	modport memSide (input aluOut, wbSrc, wbReg, valid, pc);
endinterface

// File: source/regFile.sv
module regFile (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic [4:0] rsAddr,
	input logic [4:0] rtAddr,
	input logic [4:0] rdAddr,
	input logic [31:0] rdData,
	input logic rdEn,
	output logic [31:0] rs,
	output logic [31:0] rt
);

	logic [31:0] regs [0:31];

	// r0 is cleared once and never written again
	always_ff @(posedge clk)
	begin
		if (rst)
			regs[0] <= 32'h0;
		else if (rdEn && !stall && rdAddr != 5'd0)
			regs[rdAddr] <= rdData;
	end

	// Same-cycle write is visible to the decoder
	assign rs = (rdEn && rdAddr == rsAddr && rsAddr != 5'd0) ? rdData : regs[rsAddr];
	assign rt = (rdEn && rdAddr == rtAddr && rtAddr != 5'd0) ? rdData : regs[rtAddr];

	// r0 reads as zero on both ports
	r0ReadsZero: assert property (
		@(posedge clk) disable iff (rst)
		(rsAddr != 5'd0 || rs == 32'h0) && (rtAddr != 5'd0 || rt == 32'h0)
	);

endmodule

// File: source/stageEx.sv
module stageEx (
	input logic clk,
	input logic rst,
	input logic stall,
	idExIf.exSide id,
	exMemIf.exSide2 mem,
	output logic [31:0] exResult,
	output logic exIsLoad,
	output logic [31:0] addrDBus,
	output logic [31:0] dataOut,
	output logic stbDBus,
	output logic memWE,
	output logic [3:0] dataMask
);

	logic [31:0] aluOut;

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb
	begin
		case (id.aluOp)
			cpuPkg::ADD: aluOut = id.opA + id.opB;
			cpuPkg::SUB: aluOut = id.opA - id.opB;
			cpuPkg::AND: aluOut = id.opA & id.opB;
			cpuPkg::OR: aluOut = id.opA | id.opB;
			cpuPkg::SLT: aluOut = {31'h0, $signed(id.opA) < $signed(id.opB)};
			cpuPkg::LUI: aluOut = {id.opB[15:0], 16'h0};
			default: aluOut = id.opA + id.opB;
		endcase
	end

	// Forwarded back to decode
	assign exResult = aluOut;
	assign exIsLoad = id.valid && id.memRead;

	//////////////////////////////
	// Data bus
	//////////////////////////////
	// Address comes straight from the adder
	assign addrDBus = aluOut;
	assign dataOut = id.storeData;
	assign stbDBus = id.valid && (id.memRead || id.memWrite);
	assign memWE = id.valid && id.memWrite;
	assign dataMask = memWE ? 4'hF : 4'h0;

	//////////////////////////////
	// EX/MEM register
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
			mem.valid <= 1'b0;
		else if (!stall)
			mem.valid <= id.valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			mem.aluOut <= aluOut;
			mem.wbSrc <= id.wbSrc;
			mem.wbReg <= id.wbReg;
			mem.pc <= id.pc;
		end
	end

	// Only whole-word accesses exist
	wordAligned: assert property (
		@(posedge clk) disable iff (rst)
		stbDBus |-> addrDBus[1:0] == 2'b00
	);

endmodule

// File: source/stageId.sv
module stageId (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic flush,
	input cpuPkg::instWord_t instIn,
	input logic [31:0] pc,
	input logic [31:0] rsFwd,
	input logic [31:0] rtFwd,
	output logic [4:0] rsAddr,
	output logic [4:0] rtAddr,
	output logic rsUse,
	output logic rtUse,
	output logic [31:0] nextPC,
	output logic branchTaken,
	idExIf.idSide ex
);

	cpuPkg::instWord_t inst;
	logic [31:0] idPc;
	logic idValid;
	logic [31:0] immSext;
	logic [31:0] opB;
	cpuPkg::aluOp_t aluOp;
	cpuPkg::wbSrc_t wbSrc;
	logic [4:0] wbReg;
	logic memRead, memWrite;
	logic needRs, needRt;
	logic isBeq, isBne;

	//////////////////////////////
	// IF/ID register
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
			idValid <= 1'b0;
		else if (!stall)
			idValid <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			inst <= instIn;
			idPc <= pc;
		end
	end

	//////////////////////////////
	// Decode
	//////////////////////////////
	assign rsAddr = inst.iType.rs;
	assign rtAddr = inst.iType.rt;
	assign immSext = {{16{inst.iType.imm[15]}}, inst.iType.imm};

	always_comb
	begin
		aluOp = cpuPkg::ADD;
		wbSrc = cpuPkg::ALU;
		wbReg = 5'd0;
		opB = immSext;
		memRead = 1'b0;
		memWrite = 1'b0;
		needRs = 1'b1;
		needRt = 1'b0;
		isBeq = 1'b0;
		isBne = 1'b0;
		case (inst.iType.op)
			cpuPkg::OP_RTYPE:
			begin
				needRt = 1'b1;
				opB = rtFwd;
				wbReg = inst.rType.rd;
				case (inst.rType.funct)
					cpuPkg::FN_ADDU: aluOp = cpuPkg::ADD;
					cpuPkg::FN_SUBU: aluOp = cpuPkg::SUB;
					cpuPkg::FN_AND: aluOp = cpuPkg::AND;
					cpuPkg::FN_OR: aluOp = cpuPkg::OR;
					cpuPkg::FN_SLT: aluOp = cpuPkg::SLT;
					default: wbReg = 5'd0;
				endcase
			end
			cpuPkg::OP_ADDIU: wbReg = inst.iType.rt;
			cpuPkg::OP_ORI:
			begin
				aluOp = cpuPkg::OR;
				opB = {16'h0, inst.iType.imm};
				wbReg = inst.iType.rt;
			end
			cpuPkg::OP_LUI:
			begin
				aluOp = cpuPkg::LUI;
				needRs = 1'b0;
				wbReg = inst.iType.rt;
			end
			cpuPkg::OP_LW:
			begin
				memRead = 1'b1;
				wbSrc = cpuPkg::MEM;
				wbReg = inst.iType.rt;
			end
			cpuPkg::OP_SW:
			begin
				memWrite = 1'b1;
				needRt = 1'b1;
			end
			cpuPkg::OP_BEQ:
			begin
				isBeq = 1'b1;
				needRt = 1'b1;
			end
			cpuPkg::OP_BNE:
			begin
				isBne = 1'b1;
				needRt = 1'b1;
			end
			// Anything else retires as a nop
			default: needRs = 1'b0;
		endcase
	end

	assign rsUse = idValid && needRs;
	assign rtUse = idValid && needRt;

	// Branch resolves here, target relative to the delay slot
	assign nextPC = idPc + 32'd4 + {immSext[29:0], 2'b00};
	assign branchTaken = idValid && ((isBeq && rsFwd == rtFwd) || (isBne && rsFwd != rtFwd));

	//////////////////////////////
	// ID/EX register
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst || flush)
			ex.valid <= 1'b0;
		else if (!stall)
			ex.valid <= idValid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			ex.opA <= rsFwd;
			ex.opB <= opB;
			ex.storeData <= rtFwd;
			ex.aluOp <= aluOp;
			ex.memRead <= memRead;
			ex.memWrite <= memWrite;
			ex.wbSrc <= wbSrc;
			ex.wbReg <= wbReg;
			ex.pc <= idPc;
		end
	end

endmodule

// File: source/stageMem.sv
module stageMem (
	input logic clk,
	input logic rst,
	input logic stall,
	exMemIf.memSide ex,
	input logic [31:0] dataIn,
	output logic [4:0] wbReg,
	output logic [31:0] wbData,
	output logic wbEn
);

	logic [31:0] loadData;

	// Sampled on the same edge that moves the load into MEM
	always_ff @(posedge clk)
	begin
		if (rst)
			loadData <= 32'h0;
		else if (!stall)
			loadData <= dataIn;
	end

	//////////////////////////////
	// Write-back
	//////////////////////////////
	assign wbReg = ex.wbReg;
	assign wbData = (ex.wbSrc == cpuPkg::MEM) ? loadData : ex.aluOut;

	// Writes are held off while the pipeline is frozen
	assign wbEn = ex.valid && ex.wbReg != 5'd0 && !stall;

endmodule

// File: verification/pcpuTb.sv
module pcpuTb;

	localparam logic [31:0] BOOT_PC = 32'h0040_0100;
	localparam int PERIOD = 4;
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int DRAIN_CYCLES = 40;

	// Encodings as given by the MIPS ISA
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	logic clk = 1'b0;
	logic rst;
	logic iStall = 1'b0;
	logic dStall = 1'b0;
	logic [31:0] addrIBus;
	logic stbIBus;
	logic [31:0] instIn;
	logic [31:0] addrDBus;
	logic [31:0] dataOut;
	logic [3:0] dataMask;
	logic memWE;
	logic stbDBus;
	logic [31:0] dataIn;
	logic [31:0] dbgIdPC;
	logic [31:0] dbgExPC;
	logic [31:0] dbgMemPC;

	logic [31:0] imem [0:IMEM_WORDS-1];
	logic [31:0] dmem [0:DMEM_WORDS-1];
	logic [31:0] fetchOffset;
	logic [31:0] refAddr [$];
	logic [31:0] refData [$];
	logic [31:0] refPc [$];
	logic [31:0] refNextPc [$];
	int progLen;
	int refSteps = 0;
	int mismatches = 0;
	int failures = 0;
	logic stallMode;
	logic [31:0] lfsr = 32'h33d8_45a1;
	logic bitA;
	logic bitB;

	pcpu #(.RESET_PC(BOOT_PC)) UUT (.clk(clk), .rst(rst), .iStall(iStall), .dStall(dStall),
		.addrIBus(addrIBus), .stbIBus(stbIBus), .instIn(instIn), .addrDBus(addrDBus),
		.dataOut(dataOut), .dataMask(dataMask), .memWE(memWE), .stbDBus(stbDBus),
		.dataIn(dataIn), .dbgIdPC(dbgIdPC), .dbgExPC(dbgExPC), .dbgMemPC(dbgMemPC));

	always #(PERIOD / 2) clk = ~clk;

	//////////////////////////////
	// Memories
	//////////////////////////////
	function automatic logic [31:0] fillWord(input int index);
		logic [31:0] v;
		v = index + 1;
		return (v * 32'h9e37_79b9) ^ 32'h0f0f_1234;
	endfunction

	assign fetchOffset = addrIBus - BOOT_PC;
	assign instIn = (fetchOffset < IMEM_WORDS * 4) ? imem[fetchOffset[7:2]] : 32'h0;
	assign dataIn = dmem[addrDBus[7:2]];

	// Refilled on every reset edge, written when a store leaves EX
	always @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= fillWord(i);
		end
		else if (stbDBus && memWE && !iStall && !dStall)
			dmem[addrDBus[7:2]] <= dataOut;
	end

	//////////////////////////////
	// Bus stalls
	//////////////////////////////
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic drawBit(output logic b);
		lfsr = lfsrStep(lfsr);
		b = lfsr[0];
	endtask

	// Each stall is high one cycle in four
	always @(posedge clk)
	begin
		#1;
		if (stallMode)
		begin
			drawBit(bitA);
			drawBit(bitB);
			iStall = bitA & bitB;
			drawBit(bitA);
			drawBit(bitB);
			dStall = bitA & bitB;
		end
		else
		begin
			iStall = 1'b0;
			dStall = 1'b0;
		end
	end

	//////////////////////////////
	// Program and ISA model
	//////////////////////////////
	function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = 32'h0;
		progLen = 0;
		// ALU chain with forwarding from EX and MEM
		emit(encodeI(OP_LUI, 5'd1, 5'd0, 16'h1234));
		emit(encodeI(OP_ORI, 5'd1, 5'd1, 16'h5678));
		emit(encodeI(OP_ADDIU, 5'd2, 5'd0, 16'h0040));
		emit(encodeI(OP_SW, 5'd1, 5'd2, 16'h0000));
		emit(encodeI(OP_ADDIU, 5'd3, 5'd0, 16'hfffb));
		emit(encodeR(FN_ADDU, 5'd4, 5'd1, 5'd3));
		emit(encodeR(FN_SUBU, 5'd5, 5'd4, 5'd1));
		emit(encodeI(OP_SW, 5'd4, 5'd2, 16'h0004));
		emit(encodeI(OP_SW, 5'd5, 5'd2, 16'h0008));
		emit(encodeR(FN_SLT, 5'd6, 5'd3, 5'd0));
		emit(encodeR(FN_SLT, 5'd7, 5'd0, 5'd3));
		emit(encodeR(FN_AND, 5'd8, 5'd1, 5'd3));
		emit(encodeR(FN_OR, 5'd9, 5'd6, 5'd8));
		emit(encodeI(OP_SW, 5'd9, 5'd2, 16'h000c));
		emit(encodeI(OP_SW, 5'd7, 5'd2, 16'h0010));
		// Load followed by use
		emit(encodeI(OP_LW, 5'd10, 5'd0, 16'h0080));
		emit(encodeR(FN_ADDU, 5'd11, 5'd10, 5'd10));
		emit(encodeI(OP_SW, 5'd11, 5'd2, 16'h0014));
		emit(encodeI(OP_LW, 5'd12, 5'd2, 16'h0000));
		emit(encodeI(OP_SW, 5'd12, 5'd2, 16'h0018));
		// Taken BEQ, untaken BNE, BNE right after a load
		emit(encodeI(OP_BEQ, 5'd1, 5'd12, 16'h0002));
		emit(encodeI(OP_ADDIU, 5'd13, 5'd0, 16'h0007));
		emit(encodeI(OP_ADDIU, 5'd13, 5'd0, 16'h0063));
		emit(encodeI(OP_SW, 5'd13, 5'd2, 16'h001c));
		emit(encodeI(OP_BNE, 5'd1, 5'd12, 16'h0002));
		emit(encodeI(OP_ADDIU, 5'd14, 5'd0, 16'h0003));
		emit(encodeI(OP_ADDIU, 5'd14, 5'd14, 16'h0001));
		emit(encodeI(OP_SW, 5'd14, 5'd2, 16'h0020));
		emit(encodeI(OP_LW, 5'd15, 5'd0, 16'h0084));
		emit(encodeI(OP_BNE, 5'd0, 5'd15, 16'h0002));
		emit(encodeI(OP_ADDIU, 5'd16, 5'd0, 16'h0011));
		emit(encodeI(OP_ADDIU, 5'd16, 5'd0, 16'h0022));
		emit(encodeI(OP_SW, 5'd16, 5'd2, 16'h0024));
		// Countdown loop, the store sits in the delay slot
		emit(encodeI(OP_ADDIU, 5'd17, 5'd0, 16'h0003));
		emit(encodeI(OP_ADDIU, 5'd18, 5'd0, 16'h0000));
		emit(encodeR(FN_ADDU, 5'd18, 5'd18, 5'd17));
		emit(encodeI(OP_ADDIU, 5'd17, 5'd17, 16'hffff));
		emit(encodeI(OP_BNE, 5'd0, 5'd17, 16'hfffd));
		emit(encodeI(OP_SW, 5'd18, 5'd2, 16'h0028));
		emit(encodeI(OP_SW, 5'd17, 5'd2, 16'h002c));
		emit(encodeI(OP_LW, 5'd19, 5'd2, 16'h002c));
		emit(encodeI(OP_BEQ, 5'd0, 5'd19, 16'h0002));
		emit(encodeI(OP_SW, 5'd19, 5'd2, 16'h0030));
		emit(encodeI(OP_SW, 5'd1, 5'd2, 16'h0034));
		emit(encodeI(OP_SW, 5'd3, 5'd2, 16'h0038));
	endtask

	// Runs the program one instruction at a time and lists its stores
	function automatic int refRun();
		logic [31:0] gpr [0:31];
		logic [31:0] mem [0:DMEM_WORDS-1];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] after;
		logic [31:0] offset;
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] ea;
		logic taken;
		int steps;
		for (int i = 0; i < 32; i++)
			gpr[i] = 32'h0;
		for (int i = 0; i < DMEM_WORDS; i++)
			mem[i] = fillWord(i);
		refAddr.delete();
		refData.delete();
		refPc.delete();
		refNextPc.delete();
		pc = BOOT_PC;
		npc = BOOT_PC + 32'd4;
		offset = 32'h0;
		steps = 0;
		while (offset < progLen * 4 && steps < 2000)
		begin
			word = imem[offset[7:2]];
			a = gpr[word[25:21]];
			b = gpr[word[20:16]];
			sext = {{16{word[15]}}, word[15:0]};
			ea = a + sext;
			taken = 1'b0;
			case (word[31:26])
				OP_RTYPE:
					case (word[5:0])
						FN_ADDU: gpr[word[15:11]] = a + b;
						FN_SUBU: gpr[word[15:11]] = a - b;
						FN_AND: gpr[word[15:11]] = a & b;
						FN_OR: gpr[word[15:11]] = a | b;
						FN_SLT: gpr[word[15:11]] = {31'h0, $signed(a) < $signed(b)};
						default: ;
					endcase
				OP_ADDIU: gpr[word[20:16]] = ea;
				OP_ORI: gpr[word[20:16]] = a | {16'h0, word[15:0]};
				OP_LUI: gpr[word[20:16]] = {word[15:0], 16'h0};
				OP_LW: gpr[word[20:16]] = mem[ea[7:2]];
				OP_SW:
				begin
					mem[ea[7:2]] = b;
					refAddr.push_back(ea);
					refData.push_back(b);
					refPc.push_back(pc);
					// Next instruction in execution order sits in decode
					refNextPc.push_back(npc);
				end
				OP_BEQ: taken = (a == b);
				OP_BNE: taken = (a != b);
				default: ;
			endcase
			gpr[0] = 32'h0;
			// The slot after a branch always runs
			after = taken ? pc + 32'd4 + {sext[29:0], 2'b00} : npc + 32'd4;
			pc = npc;
			npc = after;
			offset = pc - BOOT_PC;
			steps++;
		end
		return steps;
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected)
		begin
			mismatches++;
			$display("mismatch %s: got 32'h%h, expected 32'h%h", name, got, expected);
		end
	endtask

	task automatic applyReset(input logic withStalls);
		@(posedge clk);
		#1;
		rst = 1'b1;
		@(negedge clk);
		stallMode = withStalls;
		repeat (3) @(posedge clk);
		@(negedge clk);
		check("stbDBus", {31'h0, stbDBus}, 32'h0);
		check("memWE", {31'h0, memWE}, 32'h0);
		check("stbIBus", {31'h0, stbIBus}, 32'h0);
		check("addrIBus", addrIBus, BOOT_PC);
		@(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	// Compares every store that leaves EX against the reference list
	task automatic runPass(input logic withStalls);
		int seen;
		int drain;
		logic memPending;
		logic [31:0] memPc;
		applyReset(withStalls);
		seen = 0;
		drain = 0;
		memPending = 1'b0;
		memPc = 32'h0;
		while (drain < DRAIN_CYCLES)
		begin
			@(negedge clk);
			check("stbIBus", {31'h0, stbIBus}, 32'h1);
			// Store accepted last cycle has moved into MEM
			if (memPending)
			begin
				check("dbgMemPC", dbgMemPC, memPc);
				memPending = 1'b0;
			end
			if (stbDBus && memWE && !iStall && !dStall)
			begin
				if (seen < refAddr.size())
				begin
					check($sformatf("addrDBus of store %0d", seen), addrDBus, refAddr[seen]);
					check($sformatf("dataOut of store %0d", seen), dataOut, refData[seen]);
					check("dataMask", {28'h0, dataMask}, 32'hf);
					check($sformatf("dbgExPC of store %0d", seen), dbgExPC, refPc[seen]);
					check($sformatf("dbgIdPC of store %0d", seen), dbgIdPC, refNextPc[seen]);
					memPc = refPc[seen];
					memPending = 1'b1;
				end
				else
				begin
					failures++;
					$display("Store %0d to address %h came after the last expected store",
						seen, addrDBus);
				end
				seen++;
			end
			if (seen >= refAddr.size())
				drain++;
		end
		check("store count", seen, refAddr.size());
		$display("Run with stalls %0d done, %0d stores seen", withStalls, seen);
	endtask

	initial
	begin
		rst = 1'b1;
		stallMode = 1'b0;
		loadProgram();
		refSteps = refRun();
		$display("Reference: %0d instructions, %0d stores", refSteps, refAddr.size());
		runPass(1'b0);
		runPass(1'b1);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Two runs of at most four cycles per instruction, plus reset and drain
	initial
	begin
		longint limit;
		wait (refSteps > 0);
		limit = longint'(refSteps) * 4 * PERIOD * 2 + (2 * DRAIN_CYCLES + 100) * PERIOD;
		#(limit);
		$display("Timeout: the store sequence did not finish within %0d time units", limit);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: vlog.f
source/cpuPkg.sv
source/pipeIf.sv
source/regFile.sv
source/gprFwdUnit.sv
source/stageId.sv
source/stageEx.sv
source/stageMem.sv
source/pcpu.sv
verification/pcpuTb.sv
